//--- lookahead_route.sv
////////////////////////////////////////
// Next-hop XY route for one output
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module lookahead_route (
  input  wire noc_pkg::xy_t  position_i,
  input  wire noc_pkg::xy_t  destination_i,
  input  wire noc_pkg::port_e out_port_i,
  output noc_pkg::dir_t      next_o
);

  import noc_pkg::*;

  // Position of the router behind this output
  xy_t next_pos;

  always_comb begin
    next_pos = position_i;
    unique case (out_port_i)
      PORT_NORTH: next_pos.y = position_i.y - 1'b1;
      PORT_SOUTH: next_pos.y = position_i.y + 1'b1;
      PORT_WEST:  next_pos.x = position_i.x - 1'b1;
      PORT_EAST:  next_pos.x = position_i.x + 1'b1;
      default:    next_pos   = position_i;
    endcase
  end

  // X first, then Y, then eject
  always_comb begin
    next_o = '0;
    if (out_port_i == PORT_LOCAL) begin
      // Leaving the mesh, nothing to route
      next_o[PORT_LOCAL] = 1'b1;
    end else if (destination_i.x > next_pos.x) begin
      next_o[PORT_EAST] = 1'b1;
    end else if (destination_i.x < next_pos.x) begin
      next_o[PORT_WEST] = 1'b1;
    end else if (destination_i.y < next_pos.y) begin
      next_o[PORT_NORTH] = 1'b1;
    end else if (destination_i.y > next_pos.y) begin
      next_o[PORT_SOUTH] = 1'b1;
    end else begin
      next_o[PORT_LOCAL] = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- mesh_router.sv
////////////////////////////////////////
// 5-port mesh router top level
// Five input and five output channels
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module mesh_router (
  input  wire logic                                    clk,
  input  wire logic                                    rst,
  input  wire noc_pkg::xy_t                            position_i,
  // Input links
  input  wire noc_pkg::flit_u [noc_pkg::NUM_PORTS-1:0] data_i,
  input  wire logic [noc_pkg::NUM_PORTS-1:0]           void_i,
  output logic [noc_pkg::NUM_PORTS-1:0]                stop_o,
  // Output links
  output noc_pkg::flit_u [noc_pkg::NUM_PORTS-1:0]      data_o,
  output logic [noc_pkg::NUM_PORTS-1:0]                void_o,
  input  wire logic [noc_pkg::NUM_PORTS-1:0]           stop_i
);

  import noc_pkg::*;

  // Input side
  flit_u [NUM_PORTS-1:0] heads;
  logic  [NUM_PORTS-1:0] head_valid;
  dir_t  [NUM_PORTS-1:0] req_in;
  logic  [NUM_PORTS-1:0] pop_in;

  // Row per output, column per input
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] req_col;
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] pop_out;
  // Row per input, column per output
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] pop_col;

  ////////////////////////////////////////
  // Request and pop transposes
  ////////////////////////////////////////

  for (genvar g_i = 0; g_i < int'(NUM_PORTS); g_i++) begin : gen_xpose_row
    for (genvar g_o = 0; g_o < int'(NUM_PORTS); g_o++) begin : gen_xpose_col
      assign req_col[g_o][g_i] = req_in[g_i][g_o];
      assign pop_col[g_i][g_o] = pop_out[g_o][g_i];
    end
    // Only one output selects an input at a time
    assign pop_in[g_i] = |pop_col[g_i];
  end

  ////////////////////////////////////////
  // Channels
  ////////////////////////////////////////

  for (genvar g_p = 0; g_p < int'(NUM_PORTS); g_p++) begin : gen_port
    router_input_port input_port_inst (
      .clk          (clk),
      .rst          (rst),
      .data_i       (data_i[g_p]),
      .void_i       (void_i[g_p]),
      .stop_o       (stop_o[g_p]),
      .pop_i        (pop_in[g_p]),
      .head_o       (heads[g_p]),
      .flit_valid_o (head_valid[g_p]),
      .req_o        (req_in[g_p])
    );

    router_output_port #(
      .PORT (port_e'(g_p))
    ) output_port_inst (
      .clk          (clk),
      .rst          (rst),
      .position_i   (position_i),
      .heads_i      (heads),
      .flit_valid_i (head_valid),
      .req_i        (req_col[g_p]),
      .pop_o        (pop_out[g_p]),
      .data_o       (data_o[g_p]),
      .void_o       (void_o[g_p]),
      .stop_i       (stop_i[g_p])
    );
  end

endmodule

`default_nettype wire

//--- noc_pkg.sv
////////////////////////////////////////
// Router constants for the 5-port mesh
// Port index, direction and XY types
// Flit header and flit union
////////////////////////////////////////

`default_nettype none

package noc_pkg;

  ////////////////////////////////////////
  // Router constants
  ////////////////////////////////////////

  // Number of router ports, local plus four links
  localparam logic [2:0] NUM_PORTS = 3'd5;

  // Flit width without the two preamble bits
  localparam int unsigned DATA_WIDTH = 64;

  // Input queue depth in flits
  localparam int unsigned QUEUE_DEPTH = 4;
  localparam int unsigned PTR_WIDTH = $clog2(QUEUE_DEPTH);

  // Width of one mesh coordinate
  localparam int unsigned COORD_WIDTH = 4;

  // Message type field
  localparam int unsigned MSG_WIDTH = 5;

  // Whole flit, preamble included
  localparam int unsigned FLIT_WIDTH = DATA_WIDTH + 2;

  // Header bits left over after the routing information
  localparam int unsigned RESERVED_WIDTH =
    DATA_WIDTH - 4 * COORD_WIDTH - MSG_WIDTH - int'(NUM_PORTS);

  ////////////////////////////////////////
  // Ports and directions
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    PORT_NORTH = 3'd0,
    PORT_SOUTH = 3'd1,
    PORT_WEST  = 3'd2,
    PORT_EAST  = 3'd3,
    PORT_LOCAL = 3'd4
  } port_e;

  // One-hot, bit k selects port k
  typedef logic [NUM_PORTS-1:0] dir_t;

  // North decreases y, south increases y
  typedef struct packed {
    logic [COORD_WIDTH-1:0] x;
    logic [COORD_WIDTH-1:0] y;
  } xy_t;

  ////////////////////////////////////////
  // Flit formats
  ////////////////////////////////////////

  typedef struct packed {
    logic head;
    logic tail;
  } preamble_t;

  // Head flit layout, preamble in the top bits
  typedef struct packed {
    preamble_t               preamble;
    xy_t                     source;
    xy_t                     destination;
    logic [MSG_WIDTH-1:0]    message;
    logic [RESERVED_WIDTH-1:0] reserved;
    dir_t                    routing;
  } header_t;

  // Same word seen as header or as raw payload
  typedef union packed {
    header_t               header;
    logic [FLIT_WIDTH-1:0] raw;
  } flit_u;

endpackage

`default_nettype wire

//--- router_arbiter.sv
////////////////////////////////////////
// Round-robin arbiter of one output
// Grant held for a whole worm
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module router_arbiter (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic [noc_pkg::NUM_PORTS-1:0] request_i,
  input  wire logic                          forwarding_head_i,
  input  wire logic                          forwarding_tail_i,
  output noc_pkg::dir_t                      grant_o,
  output logic                               grant_valid_o
);

  import noc_pkg::*;

  // Search start, owner of the locked worm
  logic [2:0] ptr_q;
  logic [2:0] owner_q;
  logic       locked_q;

  logic [2:0] pick_idx;
  logic       pick_valid;
  logic [2:0] win_idx;

  ////////////////////////////////////////
  // Round-robin search
  ////////////////////////////////////////

  // Walk backwards so the nearest request after ptr_q wins
  always_comb begin
    logic [2:0] idx;
    pick_idx   = ptr_q;
    pick_valid = 1'b0;
    for (int i = int'(NUM_PORTS) - 1; i >= 0; i--) begin
      idx = 3'((int'(ptr_q) + i) % int'(NUM_PORTS));
      if (request_i[idx]) begin
        pick_idx   = idx;
        pick_valid = 1'b1;
      end
    end
  end

  // Locked owner overrides the search
  assign win_idx       = locked_q ? owner_q : pick_idx;
  assign grant_valid_o = locked_q | pick_valid;

  always_comb begin
    grant_o          = '0;
    grant_o[win_idx] = grant_valid_o;
  end

  ////////////////////////////////////////
  // Lock and priority update
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr_q    <= '0;
      owner_q  <= '0;
      locked_q <= 1'b0;
    end else if (forwarding_tail_i) begin
      // Worm done, next search starts past the winner
      locked_q <= 1'b0;
      ptr_q    <= (win_idx == NUM_PORTS - 3'd1) ? '0 : win_idx + 3'd1;
    end else if (forwarding_head_i) begin
      locked_q <= 1'b1;
      owner_q  <= win_idx;
    end
  end

endmodule

`default_nettype wire

//--- router_fifo.sv
////////////////////////////////////////
// Input flit queue of one router port
// Circular buffer with full/empty flags
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module router_fifo (
  input  wire logic           clk,
  input  wire logic           rst,
  input  wire logic           wr_i,
  input  wire noc_pkg::flit_u data_i,
  input  wire logic           rd_i,
  output noc_pkg::flit_u      data_o,
  output logic                empty_o,
  output logic                full_o
);

  import noc_pkg::*;

  // Flit storage
  flit_u mem_q [QUEUE_DEPTH];

  logic [PTR_WIDTH-1:0] wr_ptr_q;
  logic [PTR_WIDTH-1:0] rd_ptr_q;
  logic [PTR_WIDTH:0]   count_q;

  // Accepted operations
  logic do_wr;
  logic do_rd;

  assign full_o  = (count_q == (PTR_WIDTH+1)'(QUEUE_DEPTH));
  assign empty_o = (count_q == '0);

  // Write when full and read when empty are dropped
  assign do_wr = wr_i & ~full_o;
  assign do_rd = rd_i & ~empty_o;

  // Head of queue
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap at the last entry
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= (wr_ptr_q == PTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_rd) begin
        rd_ptr_q <= (rd_ptr_q == PTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Fill count follows the net change
      if (do_wr && !do_rd) begin
        count_q <= count_q + 1'b1;
      end else if (do_rd && !do_wr) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- router_input_port.sv
////////////////////////////////////////
// One router input channel
// Flit queue, link stop and held
// routing request of the current worm
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module router_input_port (
  input  wire logic           clk,
  input  wire logic           rst,
  // Upstream link
  input  wire noc_pkg::flit_u data_i,
  input  wire logic           void_i,
  output logic                stop_o,
  // Toward the output ports
  input  wire logic           pop_i,
  output noc_pkg::flit_u      head_o,
  output logic                flit_valid_o,
  output noc_pkg::dir_t       req_o
);

  import noc_pkg::*;

  logic  empty;
  logic  full;
  logic  valid_head;
  dir_t  saved_req_q;

  ////////////////////////////////////////
  // Queue
  ////////////////////////////////////////

  // Every non-void flit goes in, the queue drops it when full
  router_fifo fifo_inst (
    .clk     (clk),
    .rst     (rst),
    .wr_i    (~void_i),
    .data_i  (data_i),
    .rd_i    (pop_i),
    .data_o  (head_o),
    .empty_o (empty),
    .full_o  (full)
  );

  // Upstream holds its flit while we are full
  assign stop_o = full;

  assign flit_valid_o = ~empty;
  assign valid_head   = flit_valid_o & head_o.header.preamble.head;

  ////////////////////////////////////////
  // Worm request
  ////////////////////////////////////////

  // Routing of the head is kept until the tail leaves
  always_ff @(posedge clk) begin
    if (rst) begin
      saved_req_q <= '0;
    end else if (pop_i && flit_valid_o && head_o.header.preamble.tail) begin
      saved_req_q <= '0;
    end else if (valid_head) begin
      saved_req_q <= head_o.header.routing;
    end
  end

  // A fresh head asks directly, later flits use the held copy
  assign req_o = valid_head ? head_o.header.routing : saved_req_q;

endmodule

`default_nettype wire

//--- router_output_port.sv
////////////////////////////////////////
// One router output channel
// Worm FSM, crossbar mux, head rewrite
// and registered link output
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module router_output_port #(
  parameter noc_pkg::port_e PORT = noc_pkg::PORT_LOCAL
) (
  input  wire logic                                    clk,
  input  wire logic                                    rst,
  input  wire noc_pkg::xy_t                            position_i,
  // Queue heads of all inputs
  input  wire noc_pkg::flit_u [noc_pkg::NUM_PORTS-1:0] heads_i,
  input  wire logic [noc_pkg::NUM_PORTS-1:0]           flit_valid_i,
  input  wire logic [noc_pkg::NUM_PORTS-1:0]           req_i,
  output logic [noc_pkg::NUM_PORTS-1:0]                pop_o,
  // Downstream link
  output noc_pkg::flit_u                               data_o,
  output logic                                         void_o,
  input  wire logic                                    stop_i
);

  import noc_pkg::*;

  typedef enum logic {
    ST_WAIT_HEAD,
    ST_PAYLOAD
  } state_e;

  state_e state_q;
  state_e state_d;

  logic [NUM_PORTS-1:0] req_masked;
  dir_t  grant;
  logic  grant_valid;
  flit_u sel_flit;
  logic  sel_valid;
  flit_u out_flit;
  dir_t  next_dir;
  logic  out_ready;
  logic  fwd;

  ////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////

  // No U-turn, our own input never gets this output
  always_comb begin
    req_masked       = req_i;
    req_masked[PORT] = 1'b0;
  end

  router_arbiter arbiter_inst (
    .clk               (clk),
    .rst               (rst),
    .request_i         (req_masked),
    .forwarding_head_i (fwd & sel_flit.header.preamble.head),
    .forwarding_tail_i (fwd & sel_flit.header.preamble.tail),
    .grant_o           (grant),
    .grant_valid_o     (grant_valid)
  );

  // Crossbar column, grant is one-hot
  always_comb begin
    sel_flit  = '0;
    sel_valid = 1'b0;
    for (int k = 0; k < int'(NUM_PORTS); k++) begin
      if (grant[k]) begin
        sel_flit  = heads_i[k];
        sel_valid = flit_valid_i[k];
      end
    end
  end

  ////////////////////////////////////////
  // Worm FSM
  ////////////////////////////////////////

  // Register empty, or its flit leaves this cycle
  assign out_ready = void_o | ~stop_i;

  always_comb begin
    state_d = state_q;
    fwd     = 1'b0;
    unique case (state_q)
      ST_WAIT_HEAD: begin
        // Only a head may open a worm
        if (grant_valid && sel_valid && out_ready && sel_flit.header.preamble.head) begin
          fwd = 1'b1;
          if (!sel_flit.header.preamble.tail) begin
            state_d = ST_PAYLOAD;
          end
        end
      end
      ST_PAYLOAD: begin
        // Arbiter stays locked on the same input
        if (grant_valid && sel_valid && out_ready) begin
          fwd = 1'b1;
          if (sel_flit.header.preamble.tail) begin
            state_d = ST_WAIT_HEAD;
          end
        end
      end
      default: state_d = ST_WAIT_HEAD;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_WAIT_HEAD;
    end else begin
      state_q <= state_d;
    end
  end

  // Pop the granted queue
  assign pop_o = fwd ? grant : '0;

  ////////////////////////////////////////
  // Head rewrite
  ////////////////////////////////////////

  lookahead_route lookahead_inst (
    .position_i    (position_i),
    .destination_i (sel_flit.header.destination),
    .out_port_i    (PORT),
    .next_o        (next_dir)
  );

  // Head carries the next router's direction, payload passes raw
  always_comb begin
    out_flit = '0;
    if (sel_flit.header.preamble.head) begin
      out_flit.header         = sel_flit.header;
      out_flit.header.routing = next_dir;
    end else begin
      out_flit.raw = sel_flit.raw;
    end
  end

  ////////////////////////////////////////
  // Link output register
  ////////////////////////////////////////

  // Holds while stalled with a flit on the link
  always_ff @(posedge clk) begin
    if (rst) begin
      void_o <= 1'b1;
    end else if (out_ready) begin
      void_o <= ~fwd;
    end
  end

  always_ff @(posedge clk) begin
    if (fwd) begin
      data_o <= out_flit;
    end
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
noc_pkg.sv
router_fifo.sv
router_input_port.sv
router_arbiter.sv
lookahead_route.sv
router_output_port.sv
mesh_router.sv
tb_mesh_router.sv

//--- tb_mesh_router_tests.svh
////////////////////////////////////////
// Test sequences of the router testbench
// Reset, routing, worms, contention,
// output stalls and a full input queue
////////////////////////////////////////

`ifndef TB_MESH_ROUTER_TESTS_SVH
`define TB_MESH_ROUTER_TESTS_SVH

  task automatic test_reset_state();
    int mark;
    mark = error_count + timeout_count;
    @(negedge clk);
    check_count++;
    assert (out_void == '1) else begin
      $display("[ERROR] %0t void_o expected %b actual %b", $time, 5'b11111, out_void);
      error_count++;
    end
    check_count++;
    assert (link_stop == '0) else begin
      $display("[ERROR] %0t stop_o expected %b actual %b", $time, 5'b00000, link_stop);
      error_count++;
    end
    report_test("reset state", mark);
  endtask

  // Destinations picked so the next hop varies per output
  task automatic test_single_flit();
    int mark;
    mark = error_count + timeout_count;
    send_worm(PORT_LOCAL, PORT_NORTH, 1, '{x: 4'd3, y: 4'd2});
    send_worm(PORT_LOCAL, PORT_SOUTH, 1, '{x: 4'd3, y: 4'd6});
    send_worm(PORT_LOCAL, PORT_WEST, 1, '{x: 4'd2, y: 4'd5});
    send_worm(PORT_LOCAL, PORT_EAST, 1, '{x: 4'd4, y: 4'd1});
    // Local to local is a U-turn, so eject from north
    send_worm(PORT_NORTH, PORT_LOCAL, 1, '{x: 4'd3, y: 4'd3});
    wait_drained("single flits");
    report_test("single-flit routing", mark);
  endtask

  task automatic test_worm();
    int mark;
    mark = error_count + timeout_count;
    send_worm(PORT_WEST, PORT_EAST, 5, '{x: 4'd7, y: 4'd3});
    wait_drained("west to east worm");
    report_test("multi-flit worm", mark);
  endtask

  // Three worms fight for east
  task automatic test_contention();
    int mark;
    mark = error_count + timeout_count;
    fork
      send_worm(PORT_NORTH, PORT_EAST, 4, dest_for(PORT_EAST));
      send_worm(PORT_SOUTH, PORT_EAST, 4, dest_for(PORT_EAST));
      send_worm(PORT_LOCAL, PORT_EAST, 4, dest_for(PORT_EAST));
    join
    wait_drained("contention");
    report_test("contention", mark);
  endtask

  task automatic test_random_stalls();
    int          mark;
    int          cycles;
    logic [31:0] r;
    mark         = error_count + timeout_count;
    traffic_done = 1'b0;
    fork
      begin
        fork
          begin
            send_worm(PORT_LOCAL, PORT_EAST, 6, dest_for(PORT_EAST));
            send_worm(PORT_LOCAL, PORT_NORTH, 3, dest_for(PORT_NORTH));
          end
          begin
            send_worm(PORT_WEST, PORT_NORTH, 4, dest_for(PORT_NORTH));
            send_worm(PORT_WEST, PORT_LOCAL, 2, dest_for(PORT_LOCAL));
          end
          send_worm(PORT_NORTH, PORT_SOUTH, 5, dest_for(PORT_SOUTH));
          begin
            send_worm(PORT_EAST, PORT_WEST, 3, dest_for(PORT_WEST));
            send_worm(PORT_EAST, PORT_SOUTH, 4, dest_for(PORT_SOUTH));
          end
          send_worm(PORT_SOUTH, PORT_EAST, 3, dest_for(PORT_EAST));
        join
        traffic_done = 1'b1;
      end
      begin
        cycles = 0;
        // Each output stalls about one cycle in four
        while (!traffic_done && cycles < STALL_LIMIT) begin
          @(negedge clk);
          r        = next_rand();
          out_stop = r[4:0] & r[9:5];
          cycles++;
        end
        out_stop = '0;
      end
    join
    wait_drained("random stalls");
    report_test("random output stalls", mark);
  endtask

  // Queue of west fills while east is held
  task automatic test_full_queue();
    int mark;
    int waited;
    mark = error_count + timeout_count;
    @(negedge clk);
    out_stop[PORT_EAST] = 1'b1;
    fork
      send_worm(PORT_WEST, PORT_EAST, 10, dest_for(PORT_EAST));
      begin
        waited = 0;
        while (!link_stop[PORT_WEST] && waited < SEND_LIMIT) begin
          @(negedge clk);
          waited++;
        end
        check_count++;
        assert (link_stop[PORT_WEST]) else begin
          $display("stop_o of the west input never rose while east was stalled");
          error_count++;
        end
        repeat (12) @(negedge clk);
        out_stop[PORT_EAST] = 1'b0;
      end
    join
    wait_drained("full queue");
    report_test("full input queue", mark);
  endtask

`endif

//--- tb_mesh_router.sv
////////////////////////////////////////
// Testbench top of the 5-port router
// Clock, reset, DUT and flit scoreboard
// Output monitor with assertions
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_mesh_router;

  import noc_pkg::*;

  // Bounds of every wait loop, in cycles
  localparam int SEND_LIMIT  = 100;
  localparam int DRAIN_LIMIT = 400;
  localparam int STALL_LIMIT = 600;

  // One expected flit and the output it must leave on
  typedef struct packed {
    logic [2:0] out;
    flit_u      flit;
  } expect_t;

  logic clk;
  logic rst;

  // Link side of the DUT inputs
  flit_u [NUM_PORTS-1:0] link_data;
  logic  [NUM_PORTS-1:0] link_void;
  logic  [NUM_PORTS-1:0] link_stop;
  // Link side of the DUT outputs
  flit_u [NUM_PORTS-1:0] out_data;
  logic  [NUM_PORTS-1:0] out_void;
  logic  [NUM_PORTS-1:0] out_stop;

  expect_t exp_q [$];
  int      open_sender [NUM_PORTS];
  logic  [NUM_PORTS-1:0] hold_q;
  flit_u [NUM_PORTS-1:0] prev_data;

  logic [31:0] seed = 32'd84908;
  int seq_no        = 0;
  int tests_run     = 0;
  int check_count   = 0;
  int error_count   = 0;
  int timeout_count = 0;
  logic traffic_done;

  ////////////////////////////////////////
  // Clock and DUT
  ////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Router sits at (3,3) of the mesh
  mesh_router mesh_router_inst (
    .clk        (clk),
    .rst        (rst),
    .position_i ('{x: 4'd3, y: 4'd3}),
    .data_i     (link_data),
    .void_i     (link_void),
    .stop_o     (link_stop),
    .data_o     (out_data),
    .void_o     (out_void),
    .stop_i     (out_stop)
  );

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // 32-bit xorshift
  function automatic logic [31:0] next_rand();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  // XY rule as seen from the router behind output out
  function automatic dir_t expected_route(input int out, input xy_t dest);
    int   nx;
    int   ny;
    dir_t d;
    nx = 3;
    ny = 3;
    d  = '0;
    case (out)
      0: ny = ny - 1;
      1: ny = ny + 1;
      2: nx = nx - 1;
      3: nx = nx + 1;
      default: ;
    endcase
    if (out == 4) begin
      d[4] = 1'b1;
    end else if (int'(dest.x) > nx) begin
      d[3] = 1'b1;
    end else if (int'(dest.x) < nx) begin
      d[2] = 1'b1;
    end else if (int'(dest.y) < ny) begin
      d[0] = 1'b1;
    end else if (int'(dest.y) > ny) begin
      d[1] = 1'b1;
    end else begin
      d[4] = 1'b1;
    end
    return d;
  endfunction

  // Destination that agrees with XY order for each output
  function automatic xy_t dest_for(input int out);
    case (out)
      0:       return '{x: 4'd3, y: 4'd1};
      1:       return '{x: 4'd3, y: 4'd6};
      2:       return '{x: 4'd1, y: 4'd2};
      3:       return '{x: 4'd5, y: 4'd0};
      default: return '{x: 4'd3, y: 4'd3};
    endcase
  endfunction

  // Random word, sender in raw[42:40], sequence in raw[39:24]
  function automatic flit_u make_flit(input int sender, input bit head, input bit tail,
                                      input xy_t dest, input dir_t route);
    flit_u f;
    f.raw = {2'b00, next_rand(), next_rand()};
    if (head) begin
      f.header.source      = '{x: 4'(sender), y: 4'd3};
      f.header.destination = dest;
      f.header.message     = 5'(seq_no);
      f.header.routing     = route;
    end
    f.raw[65]    = head;
    f.raw[64]    = tail;
    f.raw[42:40] = 3'(sender);
    f.raw[39:24] = 16'(seq_no);
    return f;
  endfunction

  task automatic note_timeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    timeout_count++;
  endtask

  // Flit is taken at the next rising edge once stop_o is low
  task automatic send_flit(input int in, input int out, input flit_u f, input flit_u e);
    int      waited;
    expect_t rec;
    waited = 0;
    @(negedge clk);
    link_data[in] = f;
    link_void[in] = 1'b0;
    while (link_stop[in] && waited < SEND_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (link_stop[in]) begin
      note_timeout($sformatf("input %0d stayed stopped", in));
    end else begin
      rec.out  = 3'(out);
      rec.flit = e;
      exp_q.push_back(rec);
    end
  endtask

  task automatic send_worm(input int in, input int out, input int len, input xy_t dest);
    flit_u f;
    flit_u e;
    for (int k = 0; k < len; k++) begin
      f = make_flit(in, k == 0, k == len - 1, dest, dir_t'(1 << out));
      e = f;
      // Only the head gets its routing rewritten
      if (k == 0) begin
        e.header.routing = expected_route(out, dest);
      end
      seq_no++;
      send_flit(in, out, f, e);
    end
    @(negedge clk);
    link_void[in] = 1'b1;
  endtask

  task automatic wait_drained(input string what);
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      note_timeout($sformatf("%0d flits never arrived in %s", exp_q.size(), what));
      exp_q.delete();
    end
  endtask

  task automatic report_test(input string name, input int mark);
    tests_run++;
    $display("%-22s %0d problems", name, error_count + timeout_count - mark);
  endtask

  ////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////

  task automatic check_transfer(input int p);
    int    idx;
    int    sender;
    flit_u got;
    got    = out_data[p];
    sender = int'(got.raw[42:40]);
    idx    = -1;
    // Oldest flit of this sender for this output
    for (int i = 0; i < exp_q.size(); i++) begin
      if (idx < 0 && exp_q[i].out == 3'(p) && int'(exp_q[i].flit.raw[42:40]) == sender) begin
        idx = i;
      end
    end
    check_count++;
    assert (idx >= 0) else begin
      $display("Output %0d sent a flit nobody expects at %0t: %h", p, $time, got.raw);
      error_count++;
    end
    if (idx >= 0) begin
      check_count++;
      assert (got.raw == exp_q[idx].flit.raw) else begin
        $display("[ERROR] %0t data_o[%0d] expected %h actual %h",
                 $time, p, exp_q[idx].flit.raw, got.raw);
        error_count++;
      end
      exp_q.delete(idx);
    end
    // Whole worm must come from one sender
    if (got.header.preamble.head) begin
      open_sender[p] = sender;
    end else begin
      check_count++;
      assert (sender == open_sender[p]) else begin
        $display("[ERROR] %0t sender on data_o[%0d] expected %0d actual %0d",
                 $time, p, open_sender[p], sender);
        error_count++;
      end
    end
  endtask

  // Stalled flit must stay on the link unchanged
  task automatic check_hold(input int p);
    check_count++;
    assert (!out_void[p] && out_data[p] == prev_data[p]) else begin
      $display("[ERROR] %0t data_o[%0d] expected %h actual %h void_o expected 0 actual %b",
               $time, p, prev_data[p], out_data[p], out_void[p]);
      error_count++;
    end
  endtask

  always @(posedge clk) begin
    for (int p = 0; p < int'(NUM_PORTS); p++) begin
      if (!rst) begin
        if (hold_q[p]) begin
          check_hold(p);
        end
        if (!out_void[p] && !out_stop[p]) begin
          check_transfer(p);
        end
      end
      hold_q[p]    = !rst && out_stop[p] && !out_void[p];
      prev_data[p] = out_data[p];
    end
  end

  `include "tb_mesh_router_tests.svh"

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rst          = 1'b1;
    link_data    = '0;
    link_void    = '1;
    out_stop     = '0;
    hold_q       = '0;
    traffic_done = 1'b0;
    repeat (8) @(negedge clk);
    rst = 1'b0;

    test_reset_state();
    test_single_flit();
    test_worm();
    test_contention();
    test_random_stalls();
    test_full_queue();

    $display("Tests %0d, checks %0d, errors %0d, timeouts %0d",
             tests_run, check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0 && check_count > 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
